// File: build.f
hdl/user_ip_pkg.sv
hdl/apb_if.sv
hdl/user_gpio_regs.sv
hdl/user_pwm_timer.sv
hdl/user_ip_wrapper.sv
dv/tb_clk_gen.sv
dv/tb_user_ip_wrapper.sv

// File: Makefile
TOP = tb_user_ip_wrapper
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module user_ip_wrapper

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_user_ip_wrapper.sv
module tb_user_ip_wrapper;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 20;
  localparam int sample_dly = 5;   // Mid low phase where outputs have settled
  localparam int max_waits  = 16;
  localparam int park_picks = 12;
  localparam int pwm_runs   = 3;

  // Rough cycle budget per test with at most 5 cycles per transfer
  localparam int reset_len  = 6;
  localparam int park_len   = park_picks * 5;
  localparam int strobe_len = 40 * 2 * 5 + 5;
  localparam int input_len  = 6 * (3 + 5);
  localparam int timer_len  = 10 * 2 * 5 + 20;
  localparam int pwm_len    = pwm_runs * (9 * 64 + 2 + 6 * 5);
  localparam int iso_len    = 12 * 5;
  localparam int total_len  = reset_len + park_len + strobe_len + input_len + timer_len +
                              pwm_len + iso_len;

  logic        clk;
  logic        reset;
  logic [4:0]  sel;
  logic [15:0] gpio_in;
  logic [31:0] paddr;
  logic [2:0]  pprot;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [15:0] gpio_out;
  logic [15:0] gpio_oeb;
  logic        pready;
  logic [31:0] prdata;

  logic [31:0] lfsr_q = 32'h7624;
  int          errors = 0;
  int          checks = 0;

  // Register model
  logic [15:0] mdl_out;
  logic [15:0] mdl_oeb;
  logic [1:0]  mdl_ctrl;
  logic [15:0] mdl_period;
  logic [15:0] mdl_duty;

  tb_clk_gen i_tb_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  user_ip_wrapper i_user_ip_wrapper (
    .clk_i             (clk),
    .reset_i           (reset),
    .sel_i             (sel),
    .gpio_in_i         (gpio_in),
    .slv_apb_paddr_i   (paddr),
    .slv_apb_pprot_i   (pprot),
    .slv_apb_psel_i    (psel),
    .slv_apb_penable_i (penable),
    .slv_apb_pwrite_i  (pwrite),
    .slv_apb_pwdata_i  (pwdata),
    .slv_apb_pstrb_i   (pstrb),
    .gpio_out_o        (gpio_out),
    .gpio_oeb_o        (gpio_oeb),
    .slv_apb_pready_o  (pready),
    .slv_apb_prdata_o  (prdata)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Junk in the upper bits since the designs decode 3:2 only
  function automatic logic [31:0] rand_addr(input user_ip_pkg::reg_off_e off);
    logic [31:0] r;
    r = rand_bits(28);
    return {r[27:0], off, 2'b00};
  endfunction

  function automatic logic [15:0] byte_merge(input logic [15:0] old_val,
                                             input logic [15:0] new_val,
                                             input logic [3:0]  strb);
    logic [15:0] mask;
    mask = {{8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // Only while the bus is idle
  task automatic set_sel(input logic [4:0] s);
    @(negedge clk);
    sel = s;
    #(sample_dly);
  endtask

  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata,
                          output int waits);
    bit done;
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    done    = 1'b0;
    rdata   = '0;
    while (!done) begin
      #(sample_dly);
      if (pready) begin
        rdata = prdata;
        done  = 1'b1;
      end else if (waits == max_waits) begin
        errors++;
        $display("APB transfer to %h saw no pready after %0d wait cycles", addr, waits);
        done = 1'b1;
      end else begin
        waits++;
      end
      @(negedge clk);
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output int waits);
    logic [31:0] unused_rd;
    apb_xfer(1'b1, addr, data, strb, unused_rd, waits);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                          output int waits);
    apb_xfer(1'b0, addr, '0, '0, data, waits);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic parked_slot();
    logic [31:0] r;
    logic [4:0]  s;
    for (int i = 0; i < park_picks; i++) begin
      r = rand_bits(5);
      s = r[4:0];
      while (s == user_ip_pkg::sel_gpio_regs || s == user_ip_pkg::sel_pwm_timer) begin
        r = rand_bits(5);
        s = r[4:0];
      end
      if (i == 0) s = 5'd0;
      set_sel(s);
      check_eq($sformatf("parked sel %0d gpio_out", s), 32'h0, {16'h0, gpio_out});
      check_eq($sformatf("parked sel %0d gpio_oeb", s), 32'hffff, {16'h0, gpio_oeb});
      @(negedge clk);
      paddr   = rand_bits(32);
      pwdata  = rand_bits(32);
      r       = rand_bits(4);
      pstrb   = r[3:0];
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      #(sample_dly);
      check_eq($sformatf("parked sel %0d pready", s), 32'h0, {31'h0, pready});
      check_eq($sformatf("parked sel %0d prdata", s), 32'h0, prdata);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic gpio_strobes();
    user_ip_pkg::reg_off_e off;
    logic [31:0]           r;
    logic [31:0]           data;
    logic [31:0]           rdata;
    logic [3:0]            strb;
    int                    waits;
    set_sel(user_ip_pkg::sel_gpio_regs);
    for (int i = 0; i < 40; i++) begin
      r    = rand_bits(1);
      off  = r[0] ? user_ip_pkg::reg_1 : user_ip_pkg::reg_0;
      data = rand_bits(32);
      r    = rand_bits(4);
      strb = r[3:0];
      apb_write(rand_addr(off), data, strb, waits);
      if (off == user_ip_pkg::reg_0) mdl_out = byte_merge(mdl_out, data[15:0], strb);
      else                           mdl_oeb = byte_merge(mdl_oeb, data[15:0], strb);
      check_eq($sformatf("gpio write %0d waits", i), 32'd0, waits);
      check_eq($sformatf("gpio write %0d pin out", i), {16'h0, mdl_out}, {16'h0, gpio_out});
      check_eq($sformatf("gpio write %0d pin oeb", i), {16'h0, mdl_oeb}, {16'h0, gpio_oeb});
      apb_read(rand_addr(off), rdata, waits);
      check_eq($sformatf("gpio read %0d waits", i), 32'd0, waits);
      check_eq($sformatf("gpio read %0d data", i),
               {16'h0, (off == user_ip_pkg::reg_0) ? mdl_out : mdl_oeb}, rdata);
    end
    apb_read(rand_addr(user_ip_pkg::reg_3), rdata, waits);
    check_eq("gpio undefined reg read", 32'h0, rdata);
  endtask

  task automatic input_readback();
    logic [31:0] r;
    logic [31:0] rdata;
    int          waits;
    for (int i = 0; i < 6; i++) begin
      r = rand_bits(16);
      @(negedge clk);
      gpio_in = r[15:0];
      repeat (3) @(negedge clk);  // Past the two-flop synchronizer
      apb_read(rand_addr(user_ip_pkg::reg_2), rdata, waits);
      check_eq($sformatf("gpio IN read %0d", i), {16'h0, r[15:0]}, rdata);
    end
  endtask

  task automatic timer_regs();
    user_ip_pkg::reg_off_e off;
    logic [31:0]           r;
    logic [31:0]           data;
    logic [31:0]           rdata;
    logic [3:0]            strb;
    int                    waits;
    set_sel(user_ip_pkg::sel_pwm_timer);
    for (int i = 0; i < 10; i++) begin
      off  = (i % 2 == 0) ? user_ip_pkg::reg_1 : user_ip_pkg::reg_2;
      data = rand_bits(32);
      r    = rand_bits(4);
      strb = r[3:0];
      apb_write(rand_addr(off), data, strb, waits);
      check_eq($sformatf("timer write %0d waits", i), 32'd1, waits);
      if (off == user_ip_pkg::reg_1) mdl_period = byte_merge(mdl_period, data[15:0], strb);
      else                           mdl_duty   = byte_merge(mdl_duty, data[15:0], strb);
      apb_read(rand_addr(off), rdata, waits);
      check_eq($sformatf("timer read %0d waits", i), 32'd1, waits);
      check_eq($sformatf("timer read %0d data", i),
               {16'h0, (off == user_ip_pkg::reg_1) ? mdl_period : mdl_duty}, rdata);
    end
    apb_read(rand_addr(user_ip_pkg::reg_0), rdata, waits);
    check_eq("timer CTRL after reset", {30'h0, mdl_ctrl}, rdata);
    apb_read(rand_addr(user_ip_pkg::reg_3), rdata, waits);
    check_eq("timer COUNT while disabled", 32'h0, rdata);
  endtask

  task automatic pwm_duty();
    logic [31:0] r;
    int          p;
    int          d;
    int          high;
    int          pin_bad;
    int          waits;
    for (int run = 0; run < pwm_runs; run++) begin
      r = rand_bits(6);
      p = 4 + int'(r % 61);
      r = rand_bits(7);
      d = int'(r % (p + 1));
      apb_write(rand_addr(user_ip_pkg::reg_1), p, 4'hf, waits);
      apb_write(rand_addr(user_ip_pkg::reg_2), d, 4'hf, waits);
      apb_write(rand_addr(user_ip_pkg::reg_0), 32'h1, 4'hf, waits);
      mdl_period = 16'(p);
      mdl_duty   = 16'(d);
      mdl_ctrl   = 2'b01;
      repeat (p + 2) @(negedge clk);  // Let one full period pass
      high    = 0;
      pin_bad = 0;
      repeat (8 * p) begin
        @(negedge clk);
        if (gpio_out[0]) high++;
        if (gpio_oeb !== 16'hfffe || gpio_out[15:1] !== 15'h0) pin_bad++;
      end
      check_eq($sformatf("pwm P=%0d D=%0d high cycles", p, d), 8 * d, high);
      check_eq($sformatf("pwm P=%0d D=%0d pin mismatches", p, d), 32'h0, pin_bad);
      apb_write(rand_addr(user_ip_pkg::reg_0), 32'h0, 4'hf, waits);
      mdl_ctrl = 2'b00;
      check_eq("pwm disabled oeb", 32'hffff, {16'h0, gpio_oeb});
    end
  endtask

  task automatic slot_isolation();
    logic [31:0] r;
    logic [31:0] rdata;
    int          waits;
    r = rand_bits(16);
    apb_write(rand_addr(user_ip_pkg::reg_2), r, 4'h3, waits);
    apb_write(rand_addr(user_ip_pkg::reg_0), 32'h1, 4'hf, waits);
    mdl_duty = r[15:0];
    mdl_ctrl = 2'b01;
    set_sel(user_ip_pkg::sel_gpio_regs);
    // These would change CTRL and PERIOD if the bus leaked into the timer
    apb_write(rand_addr(user_ip_pkg::reg_0), 32'h2, 4'h1, waits);
    mdl_out = byte_merge(mdl_out, 16'h0002, 4'h1);
    apb_write(rand_addr(user_ip_pkg::reg_1), {16'h0, ~mdl_period}, 4'h3, waits);
    mdl_oeb = ~mdl_period;
    check_eq("isolation gpio pin out", {16'h0, mdl_out}, {16'h0, gpio_out});
    check_eq("isolation gpio pin oeb", {16'h0, mdl_oeb}, {16'h0, gpio_oeb});
    apb_read(rand_addr(user_ip_pkg::reg_0), rdata, waits);
    check_eq("isolation gpio OUT", {16'h0, mdl_out}, rdata);
    apb_read(rand_addr(user_ip_pkg::reg_1), rdata, waits);
    check_eq("isolation gpio OEB", {16'h0, mdl_oeb}, rdata);
    set_sel(user_ip_pkg::sel_pwm_timer);
    apb_read(rand_addr(user_ip_pkg::reg_0), rdata, waits);
    check_eq("isolation timer CTRL", {30'h0, mdl_ctrl}, rdata);
    apb_read(rand_addr(user_ip_pkg::reg_1), rdata, waits);
    check_eq("isolation timer PERIOD", {16'h0, mdl_period}, rdata);
    apb_read(rand_addr(user_ip_pkg::reg_2), rdata, waits);
    check_eq("isolation timer DUTY", {16'h0, mdl_duty}, rdata);
    check_eq("isolation timer oeb", 32'hfffe, {16'h0, gpio_oeb});
    apb_write(rand_addr(user_ip_pkg::reg_0), 32'h0, 4'hf, waits);
    mdl_ctrl = 2'b00;
  endtask

  // ----------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------
  initial begin
    sel        = '0;
    gpio_in    = '0;
    paddr      = '0;
    pprot      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    pstrb      = '0;
    mdl_out    = '0;
    mdl_oeb    = '1;
    mdl_ctrl   = '0;
    mdl_period = '0;
    mdl_duty   = '0;
    wait (reset == 1'b0);
    @(negedge clk);
    parked_slot();
    gpio_strobes();
    input_readback();
    timer_regs();
    pwm_duty();
    slot_isolation();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(total_len * 2 * clk_period);
    $display("Timeout: tests did not finish within %0d cycles", total_len * 2);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period  = 10;  // 20 ns clock
  localparam int reset_cycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the DUT's sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// File: hdl/user_ip_wrapper.sv
module user_ip_wrapper (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic [user_ip_pkg::sel_w-1:0]      sel_i,
  input  logic [user_ip_pkg::gpio_w-1:0]     gpio_in_i,
  input  logic [user_ip_pkg::apb_addr_w-1:0] slv_apb_paddr_i,
  input  logic [2:0]                         slv_apb_pprot_i,
  input  logic                               slv_apb_psel_i,
  input  logic                               slv_apb_penable_i,
  input  logic                               slv_apb_pwrite_i,
  input  logic [user_ip_pkg::apb_data_w-1:0] slv_apb_pwdata_i,
  input  logic [user_ip_pkg::apb_strb_w-1:0] slv_apb_pstrb_i,
  output logic [user_ip_pkg::gpio_w-1:0]     gpio_out_o,
  output logic [user_ip_pkg::gpio_w-1:0]     gpio_oeb_o,
  output logic                               slv_apb_pready_o,
  output logic [user_ip_pkg::apb_data_w-1:0] slv_apb_prdata_o
);

  apb_if apb_gpio ();
  apb_if apb_pwm ();

  logic [user_ip_pkg::gpio_w-1:0] gpio_regs_in;
  logic [user_ip_pkg::gpio_w-1:0] gpio_regs_out;
  logic [user_ip_pkg::gpio_w-1:0] gpio_regs_oeb;
  logic [user_ip_pkg::gpio_w-1:0] pwm_in;
  logic [user_ip_pkg::gpio_w-1:0] pwm_out;
  logic [user_ip_pkg::gpio_w-1:0] pwm_oeb;

  // ----------------------------------------------------------
  // Slot routing, unselected design sees zeros
  // ----------------------------------------------------------
  always_comb begin
    gpio_out_o = '0;  // Parked
    gpio_oeb_o = '1;
    slv_apb_pready_o = 1'b0;
    slv_apb_prdata_o = '0;
    gpio_regs_in = '0;
    pwm_in = '0;
    {apb_gpio.paddr, apb_gpio.pprot, apb_gpio.psel, apb_gpio.penable} = '0;
    {apb_gpio.pwrite, apb_gpio.pwdata, apb_gpio.pstrb} = '0;
    {apb_pwm.paddr, apb_pwm.pprot, apb_pwm.psel, apb_pwm.penable} = '0;
    {apb_pwm.pwrite, apb_pwm.pwdata, apb_pwm.pstrb} = '0;
    case (sel_i)
      user_ip_pkg::sel_gpio_regs: begin
        gpio_regs_in = gpio_in_i;
        {apb_gpio.paddr, apb_gpio.pprot, apb_gpio.psel, apb_gpio.penable} =
          {slv_apb_paddr_i, slv_apb_pprot_i, slv_apb_psel_i, slv_apb_penable_i};
        {apb_gpio.pwrite, apb_gpio.pwdata, apb_gpio.pstrb} =
          {slv_apb_pwrite_i, slv_apb_pwdata_i, slv_apb_pstrb_i};
        gpio_out_o = gpio_regs_out;
        gpio_oeb_o = gpio_regs_oeb;
        slv_apb_pready_o = apb_gpio.pready;
        slv_apb_prdata_o = apb_gpio.prdata;
      end
      user_ip_pkg::sel_pwm_timer: begin
        pwm_in = gpio_in_i;
        {apb_pwm.paddr, apb_pwm.pprot, apb_pwm.psel, apb_pwm.penable} =
          {slv_apb_paddr_i, slv_apb_pprot_i, slv_apb_psel_i, slv_apb_penable_i};
        {apb_pwm.pwrite, apb_pwm.pwdata, apb_pwm.pstrb} =
          {slv_apb_pwrite_i, slv_apb_pwdata_i, slv_apb_pstrb_i};
        gpio_out_o = pwm_out;
        gpio_oeb_o = pwm_oeb;
        slv_apb_pready_o = apb_pwm.pready;
        slv_apb_prdata_o = apb_pwm.prdata;
      end
      default: ;
    endcase
  end

  user_gpio_regs i_user_gpio_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .gpio_in_i  (gpio_regs_in),
    .apb_s      (apb_gpio.subordinate),
    .gpio_out_o (gpio_regs_out),
    .gpio_oeb_o (gpio_regs_oeb)
  );

  user_pwm_timer i_user_pwm_timer (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .gpio_in_i  (pwm_in),
    .apb_s      (apb_pwm.subordinate),
    .gpio_out_o (pwm_out),
    .gpio_oeb_o (pwm_oeb)
  );

  // Slot may only switch while the bus is idle
  a_sel_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (slv_apb_psel_i && !(slv_apb_penable_i && slv_apb_pready_o)) |=> $stable(sel_i)
  );

endmodule

// File: hdl/user_pwm_timer.sv
module user_pwm_timer (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [user_ip_pkg::gpio_w-1:0] gpio_in_i,   // Bit 1 gates the count
  apb_if.subordinate                     apb_s,
  output logic [user_ip_pkg::gpio_w-1:0] gpio_out_o,
  output logic [user_ip_pkg::gpio_w-1:0] gpio_oeb_o
);

  user_ip_pkg::reg_off_e                reg_sel;
  user_ip_pkg::apb_state_e              state_q;
  user_ip_pkg::apb_state_e              state_d;
  logic                                 wr_en;
  logic                                 period_wr;
  logic                                 enable;
  logic                                 advance;
  logic [1:0]                           ctrl_q;
  logic [user_ip_pkg::timer_width-1:0]  period_q;
  logic [user_ip_pkg::timer_width-1:0]  duty_q;
  logic [user_ip_pkg::timer_width-1:0]  count_q;
  logic                                 pwm_q;
  logic [user_ip_pkg::apb_data_w-1:0]   rd_data;

  assign reg_sel = user_ip_pkg::reg_off_e'(apb_s.paddr[3:2]);
  assign enable  = ctrl_q[0];
  assign advance = enable & (~ctrl_q[1] | gpio_in_i[1]);

  // ----------------------------------------------------------
  // Access sequencer with one wait state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      user_ip_pkg::apb_idle: begin
        if (apb_s.psel && !apb_s.penable) state_d = user_ip_pkg::apb_wait;
      end
      user_ip_pkg::apb_wait: begin
        if (!apb_s.psel) state_d = user_ip_pkg::apb_idle;  // Dropped transfer
        else if (apb_s.penable) state_d = user_ip_pkg::apb_done;
      end
      user_ip_pkg::apb_done: state_d = user_ip_pkg::apb_idle;
      default:               state_d = user_ip_pkg::apb_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_q <= user_ip_pkg::apb_idle;
    else         state_q <= state_d;
  end

  assign apb_s.pready = (state_q == user_ip_pkg::apb_done);
  assign wr_en        = apb_s.pready & apb_s.psel & apb_s.penable & apb_s.pwrite;
  assign period_wr    = wr_en & (reg_sel == user_ip_pkg::reg_1);

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q   <= '0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        user_ip_pkg::reg_0: if (apb_s.pstrb[0]) ctrl_q <= apb_s.pwdata[1:0];
        user_ip_pkg::reg_1: begin
          period_q <= user_ip_pkg::strb_merge(period_q,
                                              apb_s.pwdata[user_ip_pkg::timer_width-1:0],
                                              apb_s.pstrb[1:0]);
        end
        user_ip_pkg::reg_2: begin
          duty_q <= user_ip_pkg::strb_merge(duty_q,
                                            apb_s.pwdata[user_ip_pkg::timer_width-1:0],
                                            apb_s.pstrb[1:0]);
        end
        default: ;  // COUNT is read only
      endcase
    end
  end

  // Counter restarts on a new PERIOD
  always_ff @(posedge clk_i) begin
    if (reset_i || !enable) count_q <= '0;
    else if (period_wr || period_q == '0) count_q <= '0;
    else if (advance) begin
      if (count_q == period_q - 1) count_q <= '0;  // Wrap
      else                         count_q <= count_q + 1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) pwm_q <= 1'b0;
    else         pwm_q <= enable & (count_q < duty_q);
  end

  always_comb begin
    rd_data = '0;
    case (reg_sel)
      user_ip_pkg::reg_0: rd_data[1:0]                         = ctrl_q;
      user_ip_pkg::reg_1: rd_data[user_ip_pkg::timer_width-1:0] = period_q;
      user_ip_pkg::reg_2: rd_data[user_ip_pkg::timer_width-1:0] = duty_q;
      default:            rd_data[user_ip_pkg::timer_width-1:0] = count_q;
    endcase
  end

  assign apb_s.prdata = rd_data;

  assign gpio_out_o = {{(user_ip_pkg::gpio_w-1){1'b0}}, pwm_q};
  assign gpio_oeb_o = {{(user_ip_pkg::gpio_w-1){1'b1}}, ~enable};  // Pin 0 driven when on

  a_count_below_period : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (period_q != '0) |-> (count_q < period_q)
  );

  // Ready only inside an access phase held by the manager
  a_ready_in_access : assert property (
    @(posedge clk_i) disable iff (reset_i)
    apb_s.pready |-> (apb_s.psel && apb_s.penable)
  );

endmodule

// File: hdl/user_gpio_regs.sv
module user_gpio_regs (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [user_ip_pkg::gpio_w-1:0] gpio_in_i,
  apb_if.subordinate                     apb_s,
  output logic [user_ip_pkg::gpio_w-1:0] gpio_out_o,
  output logic [user_ip_pkg::gpio_w-1:0] gpio_oeb_o
);

  user_ip_pkg::reg_off_e                reg_sel;
  logic                                 wr_en;
  logic [user_ip_pkg::gpio_w-1:0]       out_q;
  logic [user_ip_pkg::gpio_w-1:0]       oeb_q;
  logic [user_ip_pkg::gpio_w-1:0]       sync_q1;
  logic [user_ip_pkg::gpio_w-1:0]       sync_q2;
  logic [user_ip_pkg::apb_data_w-1:0]   rd_data;

  assign reg_sel = user_ip_pkg::reg_off_e'(apb_s.paddr[3:2]);

  // No wait states, ready in first access cycle
  assign apb_s.pready = apb_s.psel & apb_s.penable;
  assign wr_en        = apb_s.pready & apb_s.pwrite;

  // ----------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    sync_q1 <= gpio_in_i;
    sync_q2 <= sync_q1;
  end

  // ----------------------------------------------------------
  // OUT / OEB registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      oeb_q <= '1;  // All pads input
    end else if (wr_en) begin
      case (reg_sel)
        user_ip_pkg::reg_0: begin
          out_q <= user_ip_pkg::strb_merge(out_q, apb_s.pwdata[user_ip_pkg::gpio_w-1:0],
                                           apb_s.pstrb[1:0]);
        end
        user_ip_pkg::reg_1: begin
          oeb_q <= user_ip_pkg::strb_merge(oeb_q, apb_s.pwdata[user_ip_pkg::gpio_w-1:0],
                                           apb_s.pstrb[1:0]);
        end
        default: ;  // IN is read only
      endcase
    end
  end

  // Read mux, zero-extended
  always_comb begin
    rd_data = '0;
    case (reg_sel)
      user_ip_pkg::reg_0: rd_data[user_ip_pkg::gpio_w-1:0] = out_q;
      user_ip_pkg::reg_1: rd_data[user_ip_pkg::gpio_w-1:0] = oeb_q;
      user_ip_pkg::reg_2: rd_data[user_ip_pkg::gpio_w-1:0] = sync_q2;
      default:            rd_data = '0;
    endcase
  end

  assign apb_s.prdata = rd_data;

  assign gpio_out_o = out_q;
  assign gpio_oeb_o = oeb_q;

  // Every completion must directly follow a setup cycle
  a_ready_after_setup : assert property (
    @(posedge clk_i) disable iff (reset_i)
    apb_s.pready |-> $past(apb_s.psel && !apb_s.penable)
  );

endmodule

// File: hdl/apb_if.sv
interface apb_if;

  logic [user_ip_pkg::apb_addr_w-1:0] paddr;
  logic [2:0]                         pprot;    // Carried, not checked
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [user_ip_pkg::apb_data_w-1:0] pwdata;
  logic [user_ip_pkg::apb_strb_w-1:0] pstrb;
  logic                               pready;
  logic [user_ip_pkg::apb_data_w-1:0] prdata;

  modport manager (
    output paddr, pprot, psel, penable, pwrite, pwdata, pstrb,
    input  pready, prdata
  );

  modport subordinate (
    input  paddr,
    input  pprot,
    input  psel,
    input  penable,
    input  pwrite,
    input  pwdata,
    input  pstrb,
    output pready,
    output prdata
  );

endinterface

// File: hdl/user_ip_pkg.sv
package user_ip_pkg;

  // ----------------------------------------------------------
  // Bus and bank widths
  // ----------------------------------------------------------
  localparam int apb_addr_w = 32;
  localparam int apb_data_w = 32;
  localparam int apb_strb_w = 4;
  localparam int gpio_w     = 16;
  localparam int sel_w      = 5;

  localparam logic [sel_w-1:0] sel_gpio_regs = 5'd1;  // Design 1
  localparam logic [sel_w-1:0] sel_pwm_timer = 5'd2;  // Design 2

  localparam int timer_width = 16;

  // Word offsets, paddr[3:2]
  typedef enum logic [1:0] {
    reg_0 = 2'd0,  // OUT / CTRL
    reg_1 = 2'd1,  // OEB / PERIOD
    reg_2 = 2'd2,  // IN / DUTY
    reg_3 = 2'd3   // COUNT, timer only
  } reg_off_e;

  // Timer access sequencer
  typedef enum logic [1:0] {
    apb_idle = 2'd0,
    apb_wait = 2'd1,
    apb_done = 2'd2
  } apb_state_e;

  // Byte-wise merge of a 16 bit register under the two low strobes
  function automatic logic [gpio_w-1:0] strb_merge(input logic [gpio_w-1:0] old_val,
                                                   input logic [gpio_w-1:0] new_val,
                                                   input logic [1:0]        strb);
    logic [gpio_w-1:0] res;
    res = old_val;
    for (int b = 0; b < 2; b++) begin
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

endpackage
